// File: design/command_parser.sv
// **************************************************
// command_parser: byte stream to framebuffer writes
// and configuration register writes
// **************************************************
`timescale 1ns/10ps
`default_nettype none
`include "led_matrix_consts.svh"

module command_parser (
    input  wire                        clk_root,
    input  wire                        rst_n,
    input  wire led_matrix_pkg::byte_t rx_byte,
    input  wire                        rx_valid,
    output led_matrix_pkg::fb_write_t  fb_wr,
    output led_matrix_pkg::cfg_write_t cfg_wr
);
    import led_matrix_pkg::*;

    parse_state_t state;

    logic     wr_en;
    fb_addr_t wr_addr;
    pixel_t   wr_data;
    logic     cfg_en_bright;
    logic     cfg_en_color;
    byte_t    cfg_data;

    col_t  pix_col;
    line_t pix_line;
    byte_t color_hi;
    logic  cfg_is_bright;   // which config opcode started the command

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state         <= idle;
            wr_en         <= 1'b0;
            cfg_en_bright <= 1'b0;
            cfg_en_color  <= 1'b0;
        end else begin
            wr_en         <= 1'b0;
            cfg_en_bright <= 1'b0;
            cfg_en_color  <= 1'b0;
            if (rx_valid) begin
                case (state)
                    idle: begin
                        case (rx_byte)
                            `LM_OP_PIXEL:  state <= pix_x;
                            `LM_OP_BRIGHT: state <= cfg_arg;
                            `LM_OP_COLOR:  state <= cfg_arg;
                            default:       state <= idle;   // stray byte
                        endcase
                    end
                    pix_x:  state <= pix_y;
                    pix_y:  state <= pix_hi;
                    pix_hi: state <= pix_lo;
                    pix_lo: begin
                        wr_en <= 1'b1;
                        state <= idle;
                    end
                    default: begin
                        cfg_en_bright <= cfg_is_bright;
                        cfg_en_color  <= !cfg_is_bright;
                        state         <= idle;
                    end
                endcase
            end
        end
    end

    // argument capture
    always_ff @(posedge clk_root) begin
        if (rx_valid) begin
            case (state)
                idle:   cfg_is_bright <= (rx_byte == `LM_OP_BRIGHT);
                pix_x:  pix_col <= rx_byte[$bits(col_t)-1:0];
                pix_y:  pix_line <= rx_byte[$bits(line_t)-1:0];
                pix_hi: color_hi <= rx_byte;
                pix_lo: begin
                    wr_addr <= {pix_line, pix_col};   // y * 16 + x
                    wr_data <= {color_hi, rx_byte};
                end
                default: cfg_data <= rx_byte;
            endcase
        end
    end

    assign fb_wr  = '{en: wr_en, addr: wr_addr, data: wr_data};
    assign cfg_wr = '{en_bright: cfg_en_bright, en_color: cfg_en_color, data: cfg_data};

endmodule

`default_nettype wire

// File: design/frame_buffer.sv
// **************************************************
// frame_buffer: pixel memory, one write port and
// registered top and bottom read ports
// **************************************************
`timescale 1ns/10ps
`default_nettype none
`include "led_matrix_consts.svh"

module frame_buffer (
    input  wire                            clk_root,
    input  wire                            rst_n,
    input  wire led_matrix_pkg::fb_write_t wr,
    input  wire led_matrix_pkg::fb_addr_t  addr_top,
    input  wire led_matrix_pkg::fb_addr_t  addr_bottom,
    output led_matrix_pkg::pixel_t         data_top,
    output led_matrix_pkg::pixel_t         data_bottom
);
    import led_matrix_pkg::*;

    localparam int FB_DEPTH = `LM_PANEL_WIDTH * `LM_PANEL_HEIGHT;

    pixel_t mem [FB_DEPTH];

    // reads see the old word on a same-address write
    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            for (int i = 0; i < FB_DEPTH; i++) begin
                mem[i] <= '0;
            end
            data_top    <= '0;
            data_bottom <= '0;
        end else begin
            if (wr.en) mem[wr.addr] <= wr.data;
            data_top    <= mem[addr_top];
            data_bottom <= mem[addr_bottom];
        end
    end

endmodule

`default_nettype wire

// File: design/led_matrix_consts.svh
// **************************************************
// led matrix constants: panel geometry, serial bit
// timing, BCM base time and command opcodes
// **************************************************
`ifndef LED_MATRIX_CONSTS_SVH
`define LED_MATRIX_CONSTS_SVH

// panel geometry
`define LM_PANEL_WIDTH 16
`define LM_PANEL_HEIGHT 8
`define LM_PANEL_HALF 4        // scan rows, each drives a top and a bottom line
`define LM_PLANES 4            // brightness planes per color

`define LM_UART_TICKS_PER_BIT 16
`define LM_BCM_BASE_TICKS 4    // oe low time of plane 0

`define LM_OP_PIXEL 8'h50
`define LM_OP_BRIGHT 8'h42
`define LM_OP_COLOR 8'h45

`endif

// File: design/led_matrix_pkg.sv
// **************************************************
// led matrix types: vectors, bus structs, parser FSM
// **************************************************
`default_nettype none

package led_matrix_pkg;

    typedef logic [3:0] col_t;
    typedef logic [2:0] line_t;
    typedef logic [1:0] scan_row_t;   // also the row address pins
    typedef logic [1:0] plane_t;
    typedef logic [6:0] fb_addr_t;
    typedef logic [15:0] pixel_t;
    typedef logic [2:0] rgb_t;        // bit 0 red, 1 green, 2 blue
    typedef logic [3:0] plane_mask_t;
    typedef logic [7:0] byte_t;

    typedef struct packed {
        logic     en;
        fb_addr_t addr;
        pixel_t   data;
    } fb_write_t;

    typedef struct packed {
        logic  en_bright;
        logic  en_color;
        byte_t data;
    } cfg_write_t;

    typedef struct packed {
        logic      load;
        col_t      col;
        scan_row_t row;
        plane_t    plane;
    } scan_pos_t;

    typedef struct packed {
        plane_mask_t bright;
        rgb_t        color;
    } panel_cfg_t;

    typedef struct packed {
        rgb_t      rgb_top;
        rgb_t      rgb_bottom;
        scan_row_t row_addr;
        logic      clk_pixel;
        logic      row_latch;
        logic      oe_n;
    } hub75_t;

    typedef enum logic [2:0] {
        idle,
        pix_x,
        pix_y,
        pix_hi,
        pix_lo,
        cfg_arg
    } parse_state_t;

endpackage

`default_nettype wire

// File: design/led_matrix_top.sv
// **************************************************
// led_matrix_top: serial command input to a 16x8
// HUB75 panel
// **************************************************
`timescale 1ns/10ps
`default_nettype none

module led_matrix_top (
    input  wire                    clk_root,
    input  wire                    rst_n,
    input  wire                    uart_rx,
    output led_matrix_pkg::hub75_t panel
);
    import led_matrix_pkg::*;

    byte_t      rx_byte;
    logic       rx_valid;
    fb_write_t  fb_wr;
    cfg_write_t cfg_wr;
    panel_cfg_t cfg;
    scan_pos_t  pos;
    fb_addr_t   addr_top;
    fb_addr_t   addr_bottom;
    pixel_t     data_top;
    pixel_t     data_bottom;
    rgb_t       rgb_top;
    rgb_t       rgb_bottom;

    uart_rx rx0 (
        .clk_root(clk_root), .rst_n(rst_n), .rx(uart_rx),
        .rx_byte(rx_byte), .rx_valid(rx_valid)
    );

    command_parser parser0 (
        .clk_root(clk_root), .rst_n(rst_n), .rx_byte(rx_byte),
        .rx_valid(rx_valid), .fb_wr(fb_wr), .cfg_wr(cfg_wr)
    );

    panel_config_regs cfg0 (
        .clk_root(clk_root), .rst_n(rst_n), .cfg_wr(cfg_wr), .cfg(cfg)
    );

    frame_buffer fb0 (
        .clk_root(clk_root), .rst_n(rst_n), .wr(fb_wr),
        .addr_top(addr_top), .addr_bottom(addr_bottom),
        .data_top(data_top), .data_bottom(data_bottom)
    );

    pixel_fetch fetch0 (
        .clk_root(clk_root), .rst_n(rst_n), .pos(pos), .cfg(cfg),
        .addr_top(addr_top), .addr_bottom(addr_bottom),
        .data_top(data_top), .data_bottom(data_bottom),
        .rgb_top(rgb_top), .rgb_bottom(rgb_bottom)
    );

    matrix_scan scan0 (
        .clk_root(clk_root), .rst_n(rst_n), .rgb_top(rgb_top),
        .rgb_bottom(rgb_bottom), .pos(pos), .panel(panel)
    );

endmodule

`default_nettype wire

// File: design/matrix_scan.sv
// **************************************************
// matrix_scan: column shift, row latch and binary
// coded output enable timing for the HUB75 panel
// **************************************************
`timescale 1ns/10ps
`default_nettype none
`include "led_matrix_consts.svh"

module matrix_scan (
    input  wire                       clk_root,
    input  wire                       rst_n,
    input  wire led_matrix_pkg::rgb_t rgb_top,
    input  wire led_matrix_pkg::rgb_t rgb_bottom,
    output led_matrix_pkg::scan_pos_t pos,
    output led_matrix_pkg::hub75_t    panel
);
    import led_matrix_pkg::*;

    localparam int OE_MAX = `LM_BCM_BASE_TICKS << (`LM_PLANES - 1);
    localparam int OE_W   = $clog2(OE_MAX);

    localparam logic [1:0] PH_LOAD = 2'd0;
    localparam logic [1:0] PH_CLK  = 2'd2;   // rgb valid, pixel clock high
    localparam logic [1:0] PH_LAST = 2'd3;

    typedef enum logic [1:0] {sc_shift, sc_latch, sc_show, sc_blank} scan_state_t;

    scan_state_t     state;
    col_t            col;
    logic [1:0]      phase;
    plane_t          plane;
    scan_row_t       row;
    scan_row_t       row_addr_q;
    logic [OE_W-1:0] oe_cnt;

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state      <= sc_shift;
            col        <= '0;
            phase      <= '0;
            plane      <= '0;
            row        <= '0;
            row_addr_q <= '0;
            oe_cnt     <= '0;
        end else begin
            case (state)
                sc_shift: begin
                    phase <= phase + 1'b1;
                    if (phase == PH_LAST) begin
                        col <= col + 1'b1;   // wraps to 0 after the last column
                        if (col == col_t'(`LM_PANEL_WIDTH - 1)) begin
                            state      <= sc_latch;
                            row_addr_q <= row;   // address moves with the latch
                        end
                    end
                end
                sc_latch: begin
                    oe_cnt <= OE_W'((`LM_BCM_BASE_TICKS << plane) - 1);
                    state  <= sc_show;
                end
                sc_show: begin
                    if (oe_cnt == '0) state <= sc_blank;
                    else oe_cnt <= oe_cnt - 1'b1;
                end
                default: begin   // one dark cycle between planes
                    state <= sc_shift;
                    if (plane == plane_t'(`LM_PLANES - 1)) begin
                        plane <= '0;
                        row   <= row + 1'b1;   // wraps after the last scan row
                    end else begin
                        plane <= plane + 1'b1;
                    end
                end
            endcase
        end
    end

    always_comb begin
        pos.load  = (state == sc_shift) && (phase == PH_LOAD);
        pos.col   = col;
        pos.row   = row;
        pos.plane = plane;
    end

    always_comb begin
        panel.rgb_top    = rgb_top;
        panel.rgb_bottom = rgb_bottom;
        panel.row_addr   = row_addr_q;
        panel.clk_pixel  = (state == sc_shift) && (phase == PH_CLK);
        panel.row_latch  = (state == sc_latch);
        panel.oe_n       = (state != sc_show);   // leds lit only while showing
    end

endmodule

`default_nettype wire

// File: design/panel_config_regs.sv
// **************************************************
// panel_config_regs: brightness and color enables
// **************************************************
`timescale 1ns/10ps
`default_nettype none

module panel_config_regs (
    input  wire                             clk_root,
    input  wire                             rst_n,
    input  wire led_matrix_pkg::cfg_write_t cfg_wr,
    output led_matrix_pkg::panel_cfg_t      cfg
);
    import led_matrix_pkg::*;

    // full color and all planes until told otherwise
    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            cfg.bright <= '1;
            cfg.color  <= '1;
        end else begin
            if (cfg_wr.en_bright) begin
                cfg.bright <= cfg_wr.data[$bits(plane_mask_t)-1:0];   // one bit per plane
            end
            if (cfg_wr.en_color) begin
                cfg.color <= cfg_wr.data[$bits(rgb_t)-1:0];   // r, g, b
            end
        end
    end

endmodule

`default_nettype wire

// File: design/pixel_fetch.sv
// **************************************************
// pixel_fetch: reads both pixels of a scan position
// and reduces them to the masked bits of one plane
// **************************************************
`timescale 1ns/10ps
`default_nettype none
`include "led_matrix_consts.svh"

module pixel_fetch (
    input  wire                             clk_root,
    input  wire                             rst_n,
    input  wire led_matrix_pkg::scan_pos_t  pos,
    input  wire led_matrix_pkg::panel_cfg_t cfg,
    output led_matrix_pkg::fb_addr_t        addr_top,
    output led_matrix_pkg::fb_addr_t        addr_bottom,
    input  wire led_matrix_pkg::pixel_t     data_top,
    input  wire led_matrix_pkg::pixel_t     data_bottom,
    output led_matrix_pkg::rgb_t            rgb_top,
    output led_matrix_pkg::rgb_t            rgb_bottom
);
    import led_matrix_pkg::*;

    logic   load_d;    // read data arrives this cycle
    plane_t plane_d;

    // plane bit of each color, then both enables
    function automatic rgb_t plane_bits(pixel_t px, plane_t p, panel_cfg_t c);
        rgb_t bits;
        bits[0] = px[2 * `LM_PLANES + p];   // red 11:8
        bits[1] = px[`LM_PLANES + p];       // green 7:4
        bits[2] = px[p];                    // blue 3:0
        return bits & c.color & {3{c.bright[p]}};
    endfunction

    // bottom line sits half a panel below
    assign addr_top    = {line_t'(pos.row), pos.col};
    assign addr_bottom = {line_t'(pos.row) + line_t'(`LM_PANEL_HALF), pos.col};

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            load_d     <= 1'b0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            load_d <= pos.load;
            if (load_d) begin
                rgb_top    <= plane_bits(data_top, plane_d, cfg);
                rgb_bottom <= plane_bits(data_bottom, plane_d, cfg);
            end
        end
    end

    always_ff @(posedge clk_root) begin
        plane_d <= pos.plane;   // follows the memory latency
    end

endmodule

`default_nettype wire

// File: design/uart_rx.sv
// **************************************************
// uart_rx: 8N1 receiver, one byte strobe per frame
// **************************************************
`timescale 1ns/10ps
`default_nettype none
`include "led_matrix_consts.svh"

module uart_rx (
    input  wire                    clk_root,
    input  wire                    rst_n,
    input  wire                    rx,
    output led_matrix_pkg::byte_t  rx_byte,
    output logic                   rx_valid
);
    import led_matrix_pkg::*;

    localparam int TICKS  = `LM_UART_TICKS_PER_BIT;
    localparam int TICK_W = $clog2(TICKS);

    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

    rx_state_t         state;
    logic [1:0]        rx_sync;   // two flop synchronizer, line idles high
    logic [TICK_W-1:0] tick_cnt;
    logic [2:0]        bit_cnt;
    byte_t             shift_reg;

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            rx_sync  <= 2'b11;
            state    <= rx_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[0], rx};
            rx_valid <= 1'b0;
            case (state)
                rx_idle: begin
                    tick_cnt <= '0;
                    if (!rx_sync[1]) state <= rx_start;    // falling edge
                end
                rx_start: begin
                    if (tick_cnt == TICK_W'(TICKS / 2 - 1)) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        // a start bit that is gone by mid-bit was a glitch
                        state    <= rx_sync[1] ? rx_idle : rx_data;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (tick_cnt == TICK_W'(TICKS - 1)) begin
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= rx_stop;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: begin    // stop bit
                    if (tick_cnt == TICK_W'(TICKS - 1)) begin
                        state    <= rx_idle;
                        rx_valid <= rx_sync[1];  // framing error drops the byte
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk_root) begin
        if (state == rx_data && tick_cnt == TICK_W'(TICKS - 1)) begin
            shift_reg <= {rx_sync[1], shift_reg[7:1]};
        end
    end

    assign rx_byte = shift_reg;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds the led matrix testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_led_matrix -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_led_matrix)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

// File: sources.f
+incdir+design
design/led_matrix_pkg.sv
design/uart_rx.sv
design/command_parser.sv
design/panel_config_regs.sv
design/frame_buffer.sv
design/pixel_fetch.sv
design/matrix_scan.sv
design/led_matrix_top.sv
tb/tb_led_matrix.sv

// File: tb/tb_led_matrix.sv
// **************************************************
// tb_led_matrix: serial commands in, HUB75 scan out,
// compared against a model of the panel
// **************************************************
`timescale 1ns/10ps
`default_nettype none
`include "led_matrix_consts.svh"

module tb_led_matrix;
    import led_matrix_pkg::*;

    localparam int BYTE_CYCLES   = 10 * `LM_UART_TICKS_PER_BIT;   // start, 8 data, stop
    localparam int FRAME_CYCLES  = 1296;   // 16 planes of 66 cycles plus their oe time
    localparam int TIMEOUT_CYCLES = 2 * (12 * 5 * BYTE_CYCLES + 8 * FRAME_CYCLES);
    localparam int FRAME_PIXELS  = `LM_PANEL_WIDTH * `LM_PANEL_HALF * `LM_PLANES;
    localparam int FRAME_LATCHES = `LM_PANEL_HALF * `LM_PLANES;

    logic   clk_root;
    logic   rst_n;
    logic   serial_in;
    hub75_t panel;

    // model of what the panel should hold
    pixel_t      fb_model [`LM_PANEL_WIDTH * `LM_PANEL_HEIGHT];
    plane_mask_t bright_model;
    rgb_t        color_model;

    string       cur_test;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_bad;
    int          cycle_cnt = 0;
    int          latches_before;

    // scan tracker of the negedge monitor
    int       mon_col;
    int       mon_plane;
    int       mon_row;
    int       oe_low;
    int       frame_cnt;
    int       latch_cnt;
    int       pix_checks;
    logic     check_en;
    logic     prev_clk;
    logic     prev_latch;
    logic     prev_oe_n;
    fb_addr_t addr_top_m;
    fb_addr_t addr_bottom_m;
    rgb_t     exp_top;
    rgb_t     exp_bottom;

    led_matrix_top dut0 (
        .clk_root(clk_root), .rst_n(rst_n), .uart_rx(serial_in), .panel(panel)
    );

    always #10 clk_root = ~clk_root;

    always @(posedge clk_root) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    task automatic value_error(input string what, input int expected, input int actual);
        $display("CHECK FAILED %s: %s expected %0h actual %0h", cur_test, what, expected, actual);
        errors++;
    endtask

    task automatic plain_error(input string msg);
        $display("ERROR in %s: %s", cur_test, msg);
        errors++;
    endtask

    // plane bit of each channel masked by both enables
    function automatic rgb_t expected_rgb(input pixel_t color, input int plane);
        logic [3:0]  red;
        logic [3:0]  green;
        logic [3:0]  blue;
        plane_mask_t on;
        red   = color[11:8] >> plane;
        green = color[7:4] >> plane;
        blue  = color[3:0] >> plane;
        on    = bright_model >> plane;
        if (!on[0]) return '0;
        return {blue[0], green[0], red[0]} & color_model;
    endfunction

    always @(negedge clk_root) begin
        if (!rst_n) begin
            mon_col    = 0;
            mon_plane  = 0;
            mon_row    = 0;
            oe_low     = 0;
            prev_clk   = 1'b0;
            prev_latch = 1'b0;
            prev_oe_n  = 1'b1;
        end else begin
            if (panel.clk_pixel && !prev_clk) begin
                if (check_en) begin
                    addr_top_m    = fb_addr_t'(mon_row * `LM_PANEL_WIDTH + mon_col);
                    addr_bottom_m = fb_addr_t'((mon_row + `LM_PANEL_HALF) * `LM_PANEL_WIDTH
                                               + mon_col);
                    exp_top    = expected_rgb(fb_model[addr_top_m], mon_plane);
                    exp_bottom = expected_rgb(fb_model[addr_bottom_m], mon_plane);
                    assert (panel.rgb_top == exp_top) else
                        value_error($sformatf("top rgb col %0d row %0d plane %0d",
                                    mon_col, mon_row, mon_plane),
                                    int'(exp_top), int'(panel.rgb_top));
                    assert (panel.rgb_bottom == exp_bottom) else
                        value_error($sformatf("bottom rgb col %0d row %0d plane %0d",
                                    mon_col, mon_row, mon_plane),
                                    int'(exp_bottom), int'(panel.rgb_bottom));
                    pix_checks++;
                end
                mon_col++;
            end
            if (panel.row_latch && !prev_latch) begin
                assert (int'(panel.row_addr) == mon_row) else
                    value_error("row address at latch", mon_row, int'(panel.row_addr));
                assert (mon_col == `LM_PANEL_WIDTH) else
                    plain_error($sformatf("latch came after %0d columns", mon_col));
                mon_col = 0;
                latch_cnt++;
            end
            if (!panel.oe_n) oe_low++;
            if (panel.oe_n && !prev_oe_n) begin   // end of one plane
                assert (oe_low == (`LM_BCM_BASE_TICKS << mon_plane)) else
                    value_error($sformatf("oe low time plane %0d", mon_plane),
                                `LM_BCM_BASE_TICKS << mon_plane, oe_low);
                oe_low = 0;
                if (mon_plane == `LM_PLANES - 1) begin
                    mon_plane = 0;
                    if (mon_row == `LM_PANEL_HALF - 1) begin
                        mon_row = 0;
                        frame_cnt++;
                    end else begin
                        mon_row++;
                    end
                end else begin
                    mon_plane++;
                end
            end
            prev_clk   = panel.clk_pixel;
            prev_latch = panel.row_latch;
            prev_oe_n  = panel.oe_n;
        end
    end

    // one 8N1 frame from a rising edge on
    task automatic send_byte(input byte_t data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        repeat (10) begin
            serial_in <= frame[0];
            frame = frame >> 1;
            repeat (`LM_UART_TICKS_PER_BIT) @(posedge clk_root);
        end
    endtask

    task automatic send_pixel(input int x, input int y, input pixel_t color);
        send_byte(`LM_OP_PIXEL);
        send_byte(byte_t'(x));
        send_byte(byte_t'(y));
        send_byte(color[15:8]);
        send_byte(color[7:0]);
        fb_model[fb_addr_t'(y * `LM_PANEL_WIDTH + x)] = color;
    endtask

    task automatic send_config(input byte_t op, input byte_t arg);
        send_byte(op);
        send_byte(arg);
        if (op == `LM_OP_BRIGHT) bright_model = arg[3:0];
        if (op == `LM_OP_COLOR) color_model = arg[2:0];
    endtask

    function automatic pixel_t random_color();
        return pixel_t'($urandom);
    endfunction

    task automatic check_idle_outputs();
        assert ({panel.rgb_top, panel.rgb_bottom, panel.clk_pixel, panel.row_latch,
                 panel.oe_n} == 9'b000000_0_0_1) else
            value_error("idle outputs", 1, int'({panel.rgb_top, panel.rgb_bottom,
                        panel.clk_pixel, panel.row_latch, panel.oe_n}));
    endtask

    task automatic wait_frame();
        int frame_at_call;
        frame_at_call = frame_cnt;
        while (frame_cnt == frame_at_call) @(posedge clk_root);
    endtask

    // compare one whole frame against the model
    task automatic check_frame();
        int pix_before;
        wait_frame();
        check_en   = 1'b1;
        pix_before = pix_checks;
        wait_frame();
        check_en = 1'b0;
        assert (pix_checks - pix_before == FRAME_PIXELS) else
            value_error("pixels checked in frame", FRAME_PIXELS, pix_checks - pix_before);
    endtask

    task automatic start_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != errors_at_start) tests_bad++;
        $display("test %s: %s", cur_test, (errors == errors_at_start) ? "ok" : "FAILED");
    endtask

    initial begin
        void'($urandom(74557));
        fb_model     = '{default: '0};   // reset clears the memory
        bright_model = '1;
        color_model  = '1;
        check_en     = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_bad    = 0;
        frame_cnt    = 0;
        latch_cnt    = 0;
        pix_checks   = 0;
        clk_root     = 1'b0;
        rst_n        = 1'b0;
        serial_in    = 1'b1;

        start_test("reset state");
        repeat (3) begin
            @(negedge clk_root);
            check_idle_outputs();
        end
        @(posedge clk_root);
        rst_n <= 1'b1;
        repeat (2) begin
            @(negedge clk_root);
            check_idle_outputs();
        end
        finish_test();

        @(posedge clk_root);
        start_test("pixel writes");
        send_pixel(0, 0, random_color());
        send_pixel(5, 1, random_color());
        send_pixel(15, 3, random_color());
        send_pixel(3, 2, random_color());
        send_pixel(7, 4, random_color());   // bottom half from here
        send_pixel(10, 5, random_color());
        send_pixel(15, 7, random_color());
        send_pixel(1, 6, random_color());
        check_frame();
        finish_test();

        start_test("brightness mask");
        send_config(`LM_OP_BRIGHT, 8'h05);   // planes 0 and 2 only
        check_frame();
        finish_test();

        start_test("color mask");
        send_config(`LM_OP_COLOR, 8'h02);    // green only
        check_frame();
        finish_test();

        start_test("bcm timing");
        wait_frame();
        latches_before = latch_cnt;
        wait_frame();
        assert (latch_cnt - latches_before == FRAME_LATCHES) else
            value_error("latches per frame", FRAME_LATCHES, latch_cnt - latches_before);
        finish_test();

        start_test("unknown opcodes");
        send_config(`LM_OP_BRIGHT, 8'h0b);   // a stray 0x7f argument would change both
        send_config(`LM_OP_COLOR, 8'h05);
        send_byte(8'h00);
        send_byte(8'h7f);
        send_pixel(9, 6, random_color());
        check_frame();
        finish_test();

        $display("%0d tests run, %0d with errors, %0d checks failed",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
